// ==== Bender.yml ====
package:
  name: memory_stage

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rv_pkg.sv
      - hdl/dbus_pkg.sv
      - hdl/mem_op_decode.sv
      - hdl/dbus_access.sv
      - hdl/mem_result_form.sv
      - hdl/memory_stage.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/memory_stage_tb.sv

// ==== hdl/dbus_access.sv ====
`timescale 1ns/1ps
`default_nettype none

module dbus_access
    import dbus_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        enable,
    input  mem_access_t access,
    output dbus_req_t   dreq,
    input  dbus_resp_t  dresp,
    output mem_word_u   read_word,
    output logic        waiting
);

    logic      done;
    logic      reply;
    mem_word_u read_q;

    // ***********************************************************
    // Transaction state
    // ***********************************************************
    assign waiting = access.active & ~done;
    assign reply   = waiting & dresp.data_ok;    // Reply for the open request

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else if (reply) begin
            done <= 1'b1;
        end else if (enable) begin
            done <= 1'b0;    // Next instruction may start
        end
    end

    // Read word, held until the next reply
    always_ff @(posedge clk) begin
        if (reply) begin
            read_q <= dresp.data;
        end
    end

    assign read_word = read_q;

    // ***********************************************************
    // Bus request
    // ***********************************************************
    always_comb begin
        dreq.valid  = waiting;
        dreq.write  = access.write;
        dreq.addr   = access.addr;
        dreq.strobe = access.strobe;
        dreq.data   = access.data;
    end

endmodule

`default_nettype wire

// ==== hdl/dbus_pkg.sv ====
`default_nettype none

`include "stage_defs.svh"

package dbus_pkg;

    typedef struct packed {
        logic                 valid;    // Level, held until data_ok
        logic                 write;
        logic [`ADDR_W-1:0]   addr;
        logic [3:0]           strobe;
        logic [`DATA_W-1:0]   data;
    } dbus_req_t;

    typedef struct packed {
        logic                 data_ok;  // One-cycle pulse
        logic [`DATA_W-1:0]   data;
    } dbus_resp_t;

    // One bus word seen as bytes or as halfwords
    typedef union packed {
        logic [3:0][7:0]   bytes;
        logic [1:0][15:0]  halves;
    } mem_word_u;

    typedef struct packed {
        logic                 active;
        logic                 write;
        logic [`ADDR_W-1:0]   addr;
        logic [3:0]           strobe;
        logic [`DATA_W-1:0]   data;
    } mem_access_t;

endpackage

`default_nettype wire

// ==== hdl/mem_op_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "stage_defs.svh"

module mem_op_decode
    import rv_pkg::*;
    import dbus_pkg::*;
(
    input  ex_mem_t     ex_mem_state,
    output mem_access_t access,
    output load_ctrl_t  load_ctrl
);

    logic               is_load;
    logic               is_store;
    logic [1:0]         size;
    logic               unsigned_ext;
    logic [1:0]         lane;
    logic [3:0]         strobe;
    logic [`DATA_W-1:0] lane_data;

    assign lane = ex_mem_state.alu_result[1:0];

    // ***********************************************************
    // Operation class
    // ***********************************************************
    always_comb begin
        is_load      = 1'b0;
        is_store     = 1'b0;
        size         = `SIZE_WORD;
        unsigned_ext = 1'b0;
        case (ex_mem_state.op)
            MOP_LB:  begin
                is_load = 1'b1;
                size    = `SIZE_BYTE;
            end
            MOP_LH:  begin
                is_load = 1'b1;
                size    = `SIZE_HALF;
            end
            MOP_LW:  is_load = 1'b1;
            MOP_LBU: begin
                is_load      = 1'b1;
                size         = `SIZE_BYTE;
                unsigned_ext = 1'b1;
            end
            MOP_LHU: begin
                is_load      = 1'b1;
                size         = `SIZE_HALF;
                unsigned_ext = 1'b1;
            end
            MOP_SB:  begin
                is_store = 1'b1;
                size     = `SIZE_BYTE;
            end
            MOP_SH:  begin
                is_store = 1'b1;
                size     = `SIZE_HALF;
            end
            MOP_SW:  is_store = 1'b1;
            default: ;    // ALU result
        endcase
        if (!ex_mem_state.valid) begin
            is_load  = 1'b0;
            is_store = 1'b0;
        end
    end

    // Strobe and replicated lanes
    always_comb begin
        case (size)
            `SIZE_BYTE: begin
                strobe    = 4'b0001 << lane;
                lane_data = {4{ex_mem_state.store_data[7:0]}};
            end
            `SIZE_HALF: begin
                strobe    = lane[1] ? 4'b1100 : 4'b0011;
                lane_data = {2{ex_mem_state.store_data[15:0]}};
            end
            default: begin
                strobe    = 4'b1111;
                lane_data = ex_mem_state.store_data;
            end
        endcase
    end

    always_comb begin
        access.active          = is_load | is_store;
        access.write           = is_store;
        access.addr            = ex_mem_state.alu_result;
        access.strobe          = is_store ? strobe : 4'b0000;    // Reads use no strobe
        access.data            = lane_data;

        load_ctrl.is_load      = is_load;
        load_ctrl.is_store     = is_store;
        load_ctrl.size         = size;
        load_ctrl.unsigned_ext = unsigned_ext;
        load_ctrl.lane         = lane;
    end

endmodule

`default_nettype wire

// ==== hdl/mem_result_form.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "stage_defs.svh"

module mem_result_form
    import rv_pkg::*;
    import dbus_pkg::*;
(
    input  ex_mem_t     ex_mem_state,
    input  load_ctrl_t  load_ctrl,
    input  mem_word_u   read_word,
    output mem_wb_t     mem_wb_state,
    output reg_writer_t forward
);

    logic [7:0]         byte_sel;
    logic [15:0]        half_sel;
    logic [`DATA_W-1:0] load_value;
    logic [`DATA_W-1:0] value;

    // ***********************************************************
    // Load alignment
    // ***********************************************************
    always_comb begin
        byte_sel = read_word.bytes[load_ctrl.lane];
        half_sel = read_word.halves[load_ctrl.lane[1]];
        case (load_ctrl.size)
            `SIZE_BYTE: begin
                if (load_ctrl.unsigned_ext) begin
                    load_value = {{(`DATA_W-8){1'b0}}, byte_sel};
                end else begin
                    load_value = {{(`DATA_W-8){byte_sel[7]}}, byte_sel};
                end
            end
            `SIZE_HALF: begin
                if (load_ctrl.unsigned_ext) begin
                    load_value = {{(`DATA_W-16){1'b0}}, half_sel};
                end else begin
                    load_value = {{(`DATA_W-16){half_sel[15]}}, half_sel};
                end
            end
            default: load_value = read_word.bytes;    // Full word
        endcase
    end

    assign value = load_ctrl.is_load ? load_value : ex_mem_state.alu_result;

    // ***********************************************************
    // Output records
    // ***********************************************************
    always_comb begin
        mem_wb_state.valid   = ex_mem_state.valid;
        mem_wb_state.op      = ex_mem_state.op;
        mem_wb_state.inst    = ex_mem_state.inst;
        mem_wb_state.inst_pc = ex_mem_state.inst_pc;
        mem_wb_state.value   = value;

        // Stores have no destination register
        forward.write_enable = ex_mem_state.valid & ~load_ctrl.is_store;
        forward.dest         = ex_mem_state.inst[11:7];    // rd
        forward.data         = value;
    end

endmodule

`default_nettype wire

// ==== hdl/memory_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module memory_stage
    import rv_pkg::*;
    import dbus_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        enable,        // Pipeline advance

    input  ex_mem_t     ex_mem_state,
    output dbus_req_t   dreq,
    input  dbus_resp_t  dresp,

    output mem_wb_t     mem_wb_state,
    output reg_writer_t forward,
    output logic        ok
);

    mem_access_t access;
    load_ctrl_t  load_ctrl;
    mem_word_u   read_word;
    logic        waiting;

    mem_op_decode u_decode (
        .ex_mem_state (ex_mem_state),
        .access       (access),
        .load_ctrl    (load_ctrl)
    );

    dbus_access u_access (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (enable),
        .access    (access),
        .dreq      (dreq),
        .dresp     (dresp),
        .read_word (read_word),
        .waiting   (waiting)
    );

    mem_result_form u_form (
        .ex_mem_state (ex_mem_state),
        .load_ctrl    (load_ctrl),
        .read_word    (read_word),
        .mem_wb_state (mem_wb_state),
        .forward      (forward)
    );

    assign ok = ~waiting;    // Low holds the pipeline

endmodule

`default_nettype wire

// ==== hdl/rv_pkg.sv ====
`default_nettype none

`include "stage_defs.svh"

package rv_pkg;

    // Memory role of an executed instruction
    typedef enum logic [3:0] {
        MOP_NONE = 4'd0,    // ALU result only
        MOP_LB   = 4'd1,
        MOP_LH   = 4'd2,
        MOP_LW   = 4'd3,
        MOP_LBU  = 4'd4,
        MOP_LHU  = 4'd5,
        MOP_SB   = 4'd6,
        MOP_SH   = 4'd7,
        MOP_SW   = 4'd8
    } mem_op_t;

    typedef struct packed {
        logic                 valid;
        mem_op_t              op;
        logic [`DATA_W-1:0]   inst;
        logic [`ADDR_W-1:0]   inst_pc;
        logic [`DATA_W-1:0]   alu_result;    // Also the access address
        logic [`DATA_W-1:0]   store_data;
    } ex_mem_t;

    typedef struct packed {
        logic                 valid;
        mem_op_t              op;
        logic [`DATA_W-1:0]   inst;
        logic [`ADDR_W-1:0]   inst_pc;
        logic [`DATA_W-1:0]   value;
    } mem_wb_t;

    typedef struct packed {
        logic                   write_enable;
        logic [`REG_IDX_W-1:0]  dest;
        logic [`DATA_W-1:0]     data;
    } reg_writer_t;

    typedef struct packed {
        logic        is_load;
        logic        is_store;
        logic [1:0]  size;
        logic        unsigned_ext;
        logic [1:0]  lane;    // Low address bits
    } load_ctrl_t;

endpackage

`default_nettype wire

// ==== hdl/stage_defs.svh ====
`ifndef STAGE_DEFS_SVH
`define STAGE_DEFS_SVH

// ***********************************************************
// Widths
// ***********************************************************
`define DATA_W    32    // Data and bus word
`define ADDR_W    32    // Byte address
`define REG_IDX_W 5     // Register file index

// ***********************************************************
// Access size codes
// ***********************************************************
`define SIZE_BYTE 2'd0
`define SIZE_HALF 2'd1
`define SIZE_WORD 2'd2

`endif

// ==== src.f ====
+incdir+hdl
hdl/rv_pkg.sv
hdl/dbus_pkg.sv
hdl/mem_op_decode.sv
hdl/dbus_access.sv
hdl/mem_result_form.sv
hdl/memory_stage.sv
testbench/memory_stage_tb.sv

// ==== testbench/memory_stage_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "stage_defs.svh"

module memory_stage_tb
    import rv_pkg::*;
    import dbus_pkg::*;
();

    localparam int WAIT_LIMIT = 40;    // Cycles until a stuck access is reported

    logic        clk;
    logic        rst_n;
    logic        enable;
    ex_mem_t     ex_mem_state;
    dbus_req_t   dreq;
    dbus_resp_t  dresp;
    mem_wb_t     mem_wb_state;
    reg_writer_t forward;
    logic        ok;

    // Expected behaviour of the instruction in flight
    logic               exp_valid;
    logic               exp_mem;
    logic               exp_store;
    logic [`ADDR_W-1:0] exp_addr;
    logic [3:0]         exp_strobe;
    logic [`DATA_W-1:0] exp_wdata;
    logic [`DATA_W-1:0] exp_value;
    logic [4:0]         exp_rd;
    logic               answered;    // Reply seen, no enable yet

    logic [`DATA_W-1:0] ref_mem [16];
    logic [`DATA_W-1:0] bus_mem [16];
    dbus_req_t          held_req;
    int                 req_count;
    int                 bus_delay;
    logic [7:0]         lfsr_state;
    logic [`ADDR_W-1:0] pc;

    memory_stage DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .enable       (enable),
        .ex_mem_state (ex_mem_state),
        .dreq         (dreq),
        .dresp        (dresp),
        .mem_wb_state (mem_wb_state),
        .forward      (forward),
        .ok           (ok)
    );

    always #4 clk = ~clk;

    // ***********************************************************
    // Helpers
    // ***********************************************************
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};    // x^8+x^6+x^5+x^4+1
    endfunction

    task automatic draw_delay(output int cycles);
        int raw;
        raw = 0;
        for (int i = 0; i < 3; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            raw = (raw << 1) | int'(lfsr_state[0]);
        end
        cycles = raw % 6;
    endtask

    function automatic logic [3:0] strobe_for(input mem_op_t op, input logic [1:0] lane);
        case (op)
            MOP_SB:  return 4'b0001 << lane;
            MOP_SH:  return 4'b0011 << {lane[1], 1'b0};
            default: return 4'b1111;
        endcase
    endfunction

    function automatic logic [`DATA_W-1:0] lanes_for(input mem_op_t op,
                                                     input logic [`DATA_W-1:0] data);
        case (op)
            MOP_SB:  return {4{data[7:0]}};
            MOP_SH:  return {2{data[15:0]}};
            default: return data;
        endcase
    endfunction

    function automatic logic [`DATA_W-1:0] load_for(input mem_op_t op,
                                                    input logic [`DATA_W-1:0] word,
                                                    input logic [1:0] lane);
        logic [`DATA_W-1:0] shifted;
        shifted = word >> (8 * lane);
        case (op)
            MOP_LB:  return {{24{shifted[7]}}, shifted[7:0]};
            MOP_LBU: return {24'h0, shifted[7:0]};
            MOP_LH:  return {{16{shifted[15]}}, shifted[15:0]};
            MOP_LHU: return {16'h0, shifted[15:0]};
            default: return word;
        endcase
    endfunction

    function automatic logic [`DATA_W-1:0] merge_bytes(input logic [`DATA_W-1:0] old_word,
                                                       input logic [3:0] strobe,
                                                       input logic [`DATA_W-1:0] data);
        logic [`DATA_W-1:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strobe[b]) result[8*b +: 8] = data[8*b +: 8];
        end
        return result;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        $display("TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_stall(input string msg);
        $display("Timeout at %0t ns: %s", $time, msg);
        $display("TESTS FAILED");
        $fatal(1, "stopped on timeout");
    endtask

    // ***********************************************************
    // Data-bus model
    // ***********************************************************
    initial begin
        dresp     = '0;
        held_req  = '0;
        req_count = 0;
        forever begin
            @(posedge clk);
            if (rst_n && dreq.valid) begin
                held_req  = dreq;
                req_count = req_count + 1;
                draw_delay(bus_delay);
                @(negedge clk);
                repeat (bus_delay) @(negedge clk);    // 0 to 5 extra cycles
                if (held_req.write) begin
                    bus_mem[held_req.addr[5:2]] = merge_bytes(bus_mem[held_req.addr[5:2]],
                                                              held_req.strobe, held_req.data);
                    dresp.data = '0;
                end else begin
                    dresp.data = bus_mem[held_req.addr[5:2]];
                end
                dresp.data_ok = 1'b1;
                @(negedge clk);
                dresp.data_ok = 1'b0;
            end
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            answered <= 1'b0;
        end else if (dresp.data_ok && dreq.valid) begin
            answered <= 1'b1;
        end else if (enable) begin
            answered <= 1'b0;
        end
    end

    // ***********************************************************
    // Checks
    // ***********************************************************
    a_alu_no_req: assert property (@(posedge clk) disable iff (!rst_n)
        !exp_mem |-> ok && !dreq.valid) else report_mismatch("request or stall for non-memory op");
    a_wait_low: assert property (@(posedge clk) disable iff (!rst_n)
        exp_mem && !answered |-> !ok && dreq.valid) else report_mismatch("ok high while waiting");
    a_done_hold: assert property (@(posedge clk) disable iff (!rst_n)
        exp_mem && answered |-> ok && !dreq.valid) else report_mismatch("not held after reply");
    a_req_fields: assert property (@(posedge clk) disable iff (!rst_n)
        dreq.valid |-> dreq.write == exp_store && dreq.addr == exp_addr
            && (!exp_store || (dreq.strobe == exp_strobe && dreq.data == exp_wdata)))
        else report_mismatch("wrong request fields");
    a_reply_match: assert property (@(posedge clk) disable iff (!rst_n)
        dresp.data_ok |-> dreq == held_req) else report_mismatch("request changed while open");
    a_forward_we: assert property (@(posedge clk) disable iff (!rst_n)
        forward.write_enable == (exp_valid && !exp_store))
        else report_mismatch("wrong forward write_enable");
    a_forward_dest: assert property (@(posedge clk) disable iff (!rst_n)
        forward.write_enable |-> forward.dest == exp_rd) else report_mismatch("wrong forward dest");
    a_value: assert property (@(posedge clk) disable iff (!rst_n)
        ok && exp_valid && !exp_store |-> mem_wb_state.value == exp_value
            && forward.data == exp_value) else report_mismatch("wrong result value");
    a_pass: assert property (@(posedge clk) disable iff (!rst_n)
        mem_wb_state.valid == ex_mem_state.valid && mem_wb_state.op == ex_mem_state.op
            && mem_wb_state.inst == ex_mem_state.inst
            && mem_wb_state.inst_pc == ex_mem_state.inst_pc)
        else report_mismatch("MEM/WB fields not passed through");

    // ***********************************************************
    // Stimulus
    // ***********************************************************
    // Runs one instruction up to its enable; starts and ends on a falling edge
    task automatic run_instr(input mem_op_t op, input logic [`ADDR_W-1:0] addr,
                             input logic [`DATA_W-1:0] sdata, input logic [4:0] rd,
                             input logic valid, input logic poke);
        ex_mem_t instr;
        int      start_count;
        int      waited;
        instr.valid      = valid;
        instr.op         = op;
        instr.inst       = {20'h00abc, rd, 7'h03};
        instr.inst_pc    = pc;
        instr.alu_result = addr;
        instr.store_data = sdata;
        pc               = pc + 4;
        exp_valid  = valid;
        exp_store  = valid && (op == MOP_SB || op == MOP_SH || op == MOP_SW);
        exp_mem    = valid && op != MOP_NONE;
        exp_addr   = addr;
        exp_strobe = strobe_for(op, addr[1:0]);
        exp_wdata  = lanes_for(op, sdata);
        exp_rd     = rd;
        exp_value  = (exp_mem && !exp_store) ? load_for(op, ref_mem[addr[5:2]], addr[1:0]) : addr;
        if (exp_store) begin
            ref_mem[addr[5:2]] = merge_bytes(ref_mem[addr[5:2]], exp_strobe, exp_wdata);
        end
        ex_mem_state = instr;
        enable       = poke;    // Must be ignored while waiting
        start_count  = req_count;
        waited       = 0;
        do begin
            @(negedge clk);
            enable = poke & ~ok;    // Held up to the reply cycle
            waited++;
            if (waited > WAIT_LIMIT) report_stall("memory access never completed");
        end while (!ok);
        repeat (2) @(negedge clk);
        a_one_request: assert (req_count - start_count == (exp_mem ? 1 : 0))
            else report_mismatch("wrong number of bus requests");
        enable = 1'b1;
        @(negedge clk);
        enable = 1'b0;
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        enable       = 1'b0;
        ex_mem_state = '0;
        lfsr_state   = 8'd79;
        pc           = 32'h0000_1000;
        exp_valid    = 1'b0;
        exp_mem      = 1'b0;
        exp_store    = 1'b0;
        exp_addr     = '0;
        exp_strobe   = '0;
        exp_wdata    = '0;
        exp_value    = '0;
        exp_rd       = '0;
        for (int i = 0; i < 16; i++) begin
            ref_mem[i] = 32'h5A00_0000 ^ (32'(i) * 32'h0103_0507);
            bus_mem[i] = ref_mem[i];
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        a_idle: assert (ok && !dreq.valid) else report_mismatch("not idle after reset");

        run_instr(MOP_NONE, 32'h1234_5678, 32'h0, 5'd5, 1'b1, 1'b0);
        run_instr(MOP_NONE, 32'hFFFF_0001, 32'h0, 5'd31, 1'b1, 1'b0);

        run_instr(MOP_SW, 32'h0000_0100, 32'h8765_4321, 5'd1, 1'b1, 1'b0);
        for (int lane = 0; lane < 4; lane++) begin
            run_instr(MOP_SB, 32'h0000_0104 + 32'(lane), 32'h0000_007E + 32'h11 * 32'(lane),
                      5'd2, 1'b1, lane == 1);
        end
        run_instr(MOP_SH, 32'h0000_0108, 32'hABCD_7FFE, 5'd3, 1'b1, 1'b0);
        run_instr(MOP_SH, 32'h0000_010A, 32'h1234_8001, 5'd3, 1'b1, 1'b1);
        run_instr(MOP_SW, 32'h0000_010C, 32'hF00D_C0DE, 5'd4, 1'b1, 1'b0);

        for (int lane = 0; lane < 4; lane++) begin
            run_instr(MOP_LB, 32'h0000_0104 + 32'(lane), 32'h0, 5'(10 + lane), 1'b1, 1'b0);
            run_instr(MOP_LBU, 32'h0000_0104 + 32'(lane), 32'h0, 5'(14 + lane), 1'b1, lane == 2);
        end
        for (int lane = 0; lane < 4; lane += 2) begin
            run_instr(MOP_LH, 32'h0000_0108 + 32'(lane), 32'h0, 5'(20 + lane), 1'b1, 1'b0);
            run_instr(MOP_LHU, 32'h0000_0108 + 32'(lane), 32'h0, 5'(21 + lane), 1'b1, 1'b0);
        end
        run_instr(MOP_LW, 32'h0000_0100, 32'h0, 5'd6, 1'b1, 1'b1);
        run_instr(MOP_LW, 32'h0000_010C, 32'h0, 5'd7, 1'b1, 1'b0);
        run_instr(MOP_LW, 32'h0000_0114, 32'h0, 5'd8, 1'b1, 1'b0);    // Untouched word

        run_instr(MOP_SW, 32'h0000_0110, 32'hDEAD_BEEF, 5'd9, 1'b0, 1'b0);
        run_instr(MOP_LW, 32'h0000_0100, 32'h0, 5'd9, 1'b0, 1'b0);
        run_instr(MOP_LW, 32'h0000_0110, 32'h0, 5'd9, 1'b1, 1'b0);    // Still the fill value

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
